//--- verilog/conv_front_pkg.sv
`default_nettype none

package conv_front_pkg;

    ////////////////////////////////////////
    // pixel stream and image geometry
    ////////////////////////////////////////
    localparam int PIX_W = 8;                // unsigned pixel
    localparam int IMG_W = 8;                // pixels per row, also line buffer depth
    localparam int IMG_H = 6;                // rows per frame
    localparam int COL_W = $clog2(IMG_W);
    localparam int ROW_W = $clog2(IMG_H);
    localparam int TAPS  = 9;                // 3x3 window

    // arithmetic widths
    localparam int WGT_W  = 8;               // one weight byte per tap
    localparam int PROD_W = 16;              // pixel x signed byte
    localparam int RES_W  = 20;              // nine products plus headroom

    ////////////////////////////////////////
    // axi4-lite register map
    ////////////////////////////////////////
    localparam int ADDR_W = 6;
    localparam int DATA_W = 32;

    localparam logic [ADDR_W-1:0] REG_CTRL   = 'h00;   // bit 0 = mode
    localparam logic [ADDR_W-1:0] REG_W0     = 'h04;   // tap 0, top-left
    localparam logic [ADDR_W-1:0] REG_W_LAST = REG_W0 + ADDR_W'(4 * (TAPS - 1));

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // one weight byte, read as a single 8-bit weight in mode 0
    // or as two 4-bit weights in mode 1
    typedef union packed {
        logic signed [WGT_W-1:0] w8;
        struct packed {
            logic signed [WGT_W/2-1:0] w4_hi;   // channel 1
            logic signed [WGT_W/2-1:0] w4_lo;   // channel 0
        } w4;
    } weight_word_u;

endpackage

`default_nettype wire

//--- verilog/conv_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module conv_cfg_regs import conv_front_pkg::*; (
    input  wire                   clk,
    input  wire                   arst_n,
    // write address / data / response
    input  wire [ADDR_W-1:0]      awaddr,
    input  wire                   awvalid,
    output logic                  awready,
    input  wire [DATA_W-1:0]      wdata,
    input  wire [DATA_W/8-1:0]    wstrb,
    input  wire                   wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  wire                   bready,
    // read address / data
    input  wire [ADDR_W-1:0]      araddr,
    input  wire                   arvalid,
    output logic                  arready,
    output logic [DATA_W-1:0]     rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  wire                   rready,
    // configuration out to the pe row
    output logic                  mode,
    output weight_word_u          w0,
    output weight_word_u          w1,
    output weight_word_u          w2,
    output weight_word_u          w3,
    output weight_word_u          w4,
    output weight_word_u          w5,
    output weight_word_u          w6,
    output weight_word_u          w7,
    output weight_word_u          w8
);

    weight_word_u      wts [TAPS];     // kernel, row-major
    logic              wr_rdy;         // shared aw/w ready
    logic              wr_fire, rd_fire;
    logic              wr_hit, rd_hit;
    logic [ADDR_W-3:0] wr_tap, rd_tap;

    // ctrl or one of the nine word-aligned weight slots
    function automatic logic reg_hit(input logic [ADDR_W-1:0] a);
        logic in_taps;
        in_taps = (a >= REG_W0) && (a <= REG_W_LAST) && (a[1:0] == 2'b00);
        return (a == REG_CTRL) || in_taps;
    endfunction

    function automatic logic [ADDR_W-3:0] tap_idx(input logic [ADDR_W-1:0] a);
        logic [ADDR_W-1:0] off;
        off = a - REG_W0;
        return off[ADDR_W-1:2];
    endfunction

    assign wr_hit  = reg_hit(awaddr);
    assign rd_hit  = reg_hit(araddr);
    assign wr_tap  = tap_idx(awaddr);
    assign rd_tap  = tap_idx(araddr);
    assign wr_fire = wr_rdy && awvalid && wvalid;
    assign rd_fire = arready && arvalid;

    assign awready = wr_rdy;
    assign wready  = wr_rdy;

    ////////////////////////////////////////
    // write channel
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_rdy <= 1'b0;
            bvalid <= 1'b0;
            bresp  <= RESP_OKAY;
            mode   <= 1'b0;
            for (int i = 0; i < TAPS; i++) begin
                wts[i] <= '0;
            end
        end else begin
            // single-cycle ready pulse, held off while a response waits
            wr_rdy <= awvalid && wvalid && !bvalid && !wr_rdy;
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
                if (wr_hit && wstrb[0]) begin            // only byte lane 0 is mapped
                    if (awaddr == REG_CTRL) mode <= wdata[0];
                    else wts[wr_tap] <= wdata[WGT_W-1:0];
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // read channel
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rresp   <= RESP_OKAY;
        end else begin
            arready <= arvalid && !rvalid && !arready;
            if (rd_fire) begin
                rvalid <= 1'b1;
                rresp  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // read data, zero-extended byte
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            if (!rd_hit) rdata <= '0;
            else if (araddr == REG_CTRL) rdata <= {{(DATA_W-1){1'b0}}, mode};
            else rdata <= {{(DATA_W-WGT_W){1'b0}}, wts[rd_tap]};
        end
    end

    assign w0 = wts[0];   // top-left, oldest pixel
    assign w1 = wts[1];
    assign w2 = wts[2];
    assign w3 = wts[3];
    assign w4 = wts[4];   // centre
    assign w5 = wts[5];
    assign w6 = wts[6];
    assign w7 = wts[7];
    assign w8 = wts[8];   // bottom-right, newest

endmodule

`default_nettype wire

//--- verilog/window_gen.sv
`timescale 1ns/1ps
`default_nettype none

module window_gen import conv_front_pkg::*; (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire [PIX_W-1:0]             pix_data,
    input  wire                         pix_valid,
    input  wire                         pix_sof,     // first pixel of a frame
    output logic [TAPS-1:0][PIX_W-1:0]  win,         // win[0] = top-left
    output logic                        win_valid
);

    logic [PIX_W-1:0] line_a [IMG_W];   // row r-1
    logic [PIX_W-1:0] line_b [IMG_W];   // row r-2

    logic [COL_W-1:0] col_cnt;          // position of the next pixel
    logic [ROW_W-1:0] row_cnt;
    logic [COL_W-1:0] cur_col;          // position of the pixel now on the bus
    logic [ROW_W-1:0] cur_row;
    logic             col_last, row_last;
    logic             in_win;

    // sof forces the incoming pixel to (0,0)
    assign cur_col  = pix_sof ? '0 : col_cnt;
    assign cur_row  = pix_sof ? '0 : row_cnt;
    assign col_last = (cur_col == COL_W'(IMG_W - 1));
    assign row_last = (cur_row == ROW_W'(IMG_H - 1));

    // full 3x3 neighbourhood inside the image
    assign in_win = (cur_row >= ROW_W'(2)) && (cur_col >= COL_W'(2));

    ////////////////////////////////////////
    // raster counters
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col_cnt   <= '0;
            row_cnt   <= '0;
            win_valid <= 1'b0;
        end else begin
            win_valid <= pix_valid && in_win;   // window lands this same edge
            if (pix_valid) begin
                col_cnt <= col_last ? '0 : cur_col + 1'b1;
                if (col_last) begin
                    row_cnt <= row_last ? '0 : cur_row + 1'b1;   // wrap to next frame
                end else begin
                    row_cnt <= cur_row;                          // picks up sof restart
                end
            end
        end
    end

    ////////////////////////////////////////
    // line buffers and window shift
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            // column counter is the shared write pointer
            line_b[cur_col] <= line_a[cur_col];
            line_a[cur_col] <= pix_data;

            // each window row shifts left, oldest drops off
            for (int r = 0; r < 3; r++) begin
                win[3*r]   <= win[3*r+1];
                win[3*r+1] <= win[3*r+2];
            end
            win[2] <= line_b[cur_col];   // top row
            win[5] <= line_a[cur_col];   // middle row
            win[8] <= pix_data;          // bottom row, newest
        end
    end

endmodule

`default_nettype wire

//--- verilog/pe_row.sv
`timescale 1ns/1ps
`default_nettype none

module pe_row import conv_front_pkg::*; (
    input  wire                                 clk,
    input  wire                                 arst_n,
    input  wire [TAPS-1:0][PIX_W-1:0]           win,
    input  wire                                 win_valid,
    input  wire                                 mode,        // 0 = 8-bit, 1 = dual 4-bit
    input  wire weight_word_u                   w0,
    input  wire weight_word_u                   w1,
    input  wire weight_word_u                   w2,
    input  wire weight_word_u                   w3,
    input  wire weight_word_u                   w4,
    input  wire weight_word_u                   w5,
    input  wire weight_word_u                   w6,
    input  wire weight_word_u                   w7,
    input  wire weight_word_u                   w8,
    output logic signed [TAPS-1:0][PROD_W-1:0]  prod_ch0,
    output logic signed [TAPS-1:0][PROD_W-1:0]  prod_ch1,
    output logic                                prod_valid
);

    weight_word_u [TAPS-1:0]     wts;
    logic [TAPS-1:0][PROD_W-1:0] mul_ch0;
    logic [TAPS-1:0][PROD_W-1:0] mul_ch1;

    assign wts = {w8, w7, w6, w5, w4, w3, w2, w1, w0};   // tap 0 in the low slot

    ////////////////////////////////////////
    // nine multipliers
    ////////////////////////////////////////
    for (genvar i = 0; i < TAPS; i++) begin : g_pe
        logic signed [PROD_W-1:0] pix_s;     // pixel, zero-extended
        logic signed [PROD_W-1:0] wt_byte;   // mode 0 weight
        logic signed [PROD_W-1:0] wt_lo;     // mode 1, channel 0
        logic signed [PROD_W-1:0] wt_hi;     // mode 1, channel 1

        assign pix_s   = {{(PROD_W-PIX_W){1'b0}}, win[i]};
        assign wt_byte = {{(PROD_W-WGT_W){wts[i].w8[WGT_W-1]}}, wts[i].w8};
        assign wt_lo   = {{(PROD_W-WGT_W/2){wts[i].w4.w4_lo[WGT_W/2-1]}}, wts[i].w4.w4_lo};
        assign wt_hi   = {{(PROD_W-WGT_W/2){wts[i].w4.w4_hi[WGT_W/2-1]}}, wts[i].w4.w4_hi};

        // 255 * -128 still fits in PROD_W
        assign mul_ch0[i] = mode ? pix_s * wt_lo : pix_s * wt_byte;
        assign mul_ch1[i] = pix_s * wt_hi;   // runs in both modes
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= win_valid;
        end
    end

    // products only move with a new window
    always_ff @(posedge clk) begin
        if (win_valid) begin
            prod_ch0 <= mul_ch0;
            prod_ch1 <= mul_ch1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sum_stage.sv
`timescale 1ns/1ps
`default_nettype none

module sum_stage import conv_front_pkg::*; (
    input  wire                                 clk,
    input  wire                                 arst_n,
    input  wire signed [TAPS-1:0][PROD_W-1:0]   prod_ch0,
    input  wire signed [TAPS-1:0][PROD_W-1:0]   prod_ch1,
    input  wire                                 prod_valid,
    output logic signed [RES_W-1:0]             res_ch0,
    output logic signed [RES_W-1:0]             res_ch1,     // mode 1 only
    output logic                                res_valid
);

    logic signed [RES_W-1:0] sum_ch0;
    logic signed [RES_W-1:0] sum_ch1;

    ////////////////////////////////////////
    // adder tree, flat in rtl
    ////////////////////////////////////////
    always_comb begin
        sum_ch0 = '0;
        sum_ch1 = '0;
        for (int i = 0; i < TAPS; i++) begin
            // element selects are unsigned, extend the sign by hand
            sum_ch0 = sum_ch0 + $signed({{(RES_W-PROD_W){prod_ch0[i][PROD_W-1]}}, prod_ch0[i]});
            sum_ch1 = sum_ch1 + $signed({{(RES_W-PROD_W){prod_ch1[i][PROD_W-1]}}, prod_ch1[i]});
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= prod_valid;
        end
    end

    // result registers, hold between windows
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            res_ch0 <= sum_ch0;
            res_ch1 <= sum_ch1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/conv_datapath_front.sv
`timescale 1ns/1ps
`default_nettype none

module conv_datapath_front import conv_front_pkg::*; (
    input  wire                     clk,
    input  wire                     arst_n,
    // axi4-lite slave
    input  wire [ADDR_W-1:0]        awaddr,
    input  wire                     awvalid,
    output logic                    awready,
    input  wire [DATA_W-1:0]        wdata,
    input  wire [DATA_W/8-1:0]      wstrb,
    input  wire                     wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  wire                     bready,
    input  wire [ADDR_W-1:0]        araddr,
    input  wire                     arvalid,
    output logic                    arready,
    output logic [DATA_W-1:0]       rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  wire                     rready,
    // pixel stream in, raster order
    input  wire [PIX_W-1:0]         pix_data,
    input  wire                     pix_valid,
    input  wire                     pix_sof,
    // results, 3 cycles after the last pixel of each window
    output logic signed [RES_W-1:0] res_ch0,
    output logic signed [RES_W-1:0] res_ch1,
    output logic                    res_valid
);

    logic                              mode;
    weight_word_u                      w0, w1, w2, w3, w4, w5, w6, w7, w8;
    logic [TAPS-1:0][PIX_W-1:0]        win;
    logic                              win_valid;
    logic signed [TAPS-1:0][PROD_W-1:0] prod_ch0, prod_ch1;
    logic                              prod_valid;

    ////////////////////////////////////////
    // config slave
    ////////////////////////////////////////
    conv_cfg_regs u_cfg (
        .clk(clk), .arst_n(arst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .mode(mode),
        .w0(w0), .w1(w1), .w2(w2), .w3(w3), .w4(w4),
        .w5(w5), .w6(w6), .w7(w7), .w8(w8)
    );

    ////////////////////////////////////////
    // window -> multiply -> reduce
    ////////////////////////////////////////
    window_gen u_win (
        .clk(clk), .arst_n(arst_n),
        .pix_data(pix_data), .pix_valid(pix_valid), .pix_sof(pix_sof),
        .win(win), .win_valid(win_valid)                // stage 1
    );

    pe_row u_pe (
        .clk(clk), .arst_n(arst_n),
        .win(win), .win_valid(win_valid), .mode(mode),
        .w0(w0), .w1(w1), .w2(w2), .w3(w3), .w4(w4),
        .w5(w5), .w6(w6), .w7(w7), .w8(w8),
        .prod_ch0(prod_ch0), .prod_ch1(prod_ch1),
        .prod_valid(prod_valid)                         // stage 2
    );

    sum_stage u_sum (
        .clk(clk), .arst_n(arst_n),
        .prod_ch0(prod_ch0), .prod_ch1(prod_ch1), .prod_valid(prod_valid),
        .res_ch0(res_ch0), .res_ch1(res_ch1),
        .res_valid(res_valid)                           // stage 3
    );

endmodule

`default_nettype wire

//--- tests/conv_datapath_front_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_datapath_front_tb import conv_front_pkg::*; ();

    localparam int WINS      = (IMG_W - 2) * (IMG_H - 2);   // results per frame
    localparam int FRAME_CYC = 4 * IMG_W * IMG_H;           // frame with worst-case gaps
    localparam int REG_CYC   = 60 * 8;                      // ~60 bus accesses
    localparam int LIMIT     = 2 * (4 * FRAME_CYC + REG_CYC);

    logic clk = 1'b0;
    logic arst_n;
    logic [ADDR_W-1:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [DATA_W-1:0] wdata, rdata;
    logic [DATA_W/8-1:0] wstrb;
    logic [1:0] bresp, rresp;
    logic [PIX_W-1:0] pix_data;
    logic pix_valid, pix_sof;
    logic signed [RES_W-1:0] res_ch0, res_ch1;
    logic res_valid;

    logic [15:0] lfsr = 16'd28;
    int cyc = 0;
    int err_cnt = 0;
    int res_cnt = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    bit lat_chk = 1'b0;          // compare result cycle too

    // reference model state
    logic m_mode = 1'b0;
    logic [7:0] m_wt [TAPS];
    logic [PIX_W-1:0] frame [IMG_H][IMG_W];
    int m_row = 0;
    int m_col = 0;
    int exp_ch0[$], exp_ch1[$], exp_cyc[$];

    conv_datapath_front uut (
        .clk(clk), .arst_n(arst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .pix_data(pix_data), .pix_valid(pix_valid), .pix_sof(pix_sof),
        .res_ch0(res_ch0), .res_ch1(res_ch1), .res_valid(res_valid)
    );

    always #10 clk = ~clk;   // 20 ns period

    ////////////////////////////////////////
    // random numbers and model
    ////////////////////////////////////////
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);   // one step per bit
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // sel 0 = whole byte, 1 = low nibble, 2 = high nibble
    function automatic int tap_sum(input int r, input int c, input int sel);
        int acc;
        int w;
        acc = 0;
        for (int i = 0; i < TAPS; i++) begin
            case (sel)
                0:       w = $signed(m_wt[i]);
                1:       w = $signed(m_wt[i][3:0]);
                default: w = $signed(m_wt[i][7:4]);
            endcase
            acc += w * int'(frame[r - 2 + i / 3][c - 2 + i % 3]);   // tap 0 oldest
        end
        return acc;
    endfunction

    task automatic report_mismatch(input string name, input int exp, input int got);
        $display("Fail at %0t ns: %s expected %0d got %0d", $time, name, exp, got);
        err_cnt++;
    endtask

    // results are checked and pixels modelled where everything is stable
    always @(negedge clk) begin
        int e0, e1, ec;
        if (arst_n && res_valid) begin
            res_cnt++;
            if (exp_ch0.size() == 0) begin
                $display("Error at %0t ns: result came out with none expected", $time);
                err_cnt++;
            end else begin
                e0 = exp_ch0.pop_front();
                e1 = exp_ch1.pop_front();
                ec = exp_cyc.pop_front();
                if (int'(res_ch0) != e0) report_mismatch("res_ch0", e0, int'(res_ch0));
                if (m_mode && int'(res_ch1) != e1) report_mismatch("res_ch1", e1, int'(res_ch1));
                if (lat_chk && cyc != ec) report_mismatch("res_valid cycle", ec, cyc);
            end
        end
        if (arst_n && pix_valid) begin
            if (pix_sof) begin
                m_row = 0;
                m_col = 0;
            end
            frame[m_row][m_col] = pix_data;
            if (m_row >= 2 && m_col >= 2) begin   // full neighbourhood
                exp_ch0.push_back(tap_sum(m_row, m_col, m_mode ? 1 : 0));
                exp_ch1.push_back(tap_sum(m_row, m_col, 2));
                exp_cyc.push_back(cyc + 3);
            end
            if (m_col == IMG_W - 1) begin
                m_col = 0;
                m_row = (m_row == IMG_H - 1) ? 0 : m_row + 1;
            end else begin
                m_col++;
            end
        end
    end

    ////////////////////////////////////////
    // bus and stream drivers
    ////////////////////////////////////////
    task automatic axi_write(input logic [ADDR_W-1:0] a, input logic [7:0] d,
                             output logic [1:0] resp);
        @(posedge clk);
        awaddr  <= a;
        wdata   <= DATA_W'(d);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!awready && !wready) @(negedge clk);
        if (awready != wready) begin   // both ready lines pulse together
            $display("Error at %0t ns: awready and wready did not rise together", $time);
            err_cnt++;
        end
        @(posedge clk);   // handshake edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        resp = bresp;
    endtask

    task automatic axi_read(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d,
                            output logic [1:0] resp);
        @(posedge clk);
        araddr  <= a;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        d    = rdata;
        resp = rresp;
    endtask

    task automatic load_kernel(input logic md);
        logic [31:0] v;
        logic [1:0] resp;
        axi_write(REG_CTRL, {7'b0, md}, resp);
        m_mode = md;
        for (int i = 0; i < TAPS; i++) begin
            rand_bits(8, v);
            axi_write(REG_W0 + ADDR_W'(4 * i), v[7:0], resp);
            m_wt[i] = v[7:0];
            if (resp != RESP_OKAY) report_mismatch("bresp", RESP_OKAY, resp);
        end
    endtask

    task automatic send_frame(input int n, input bit sof, input bit gaps);
        logic [31:0] v;
        for (int i = 0; i < n; i++) begin
            if (gaps) begin
                rand_bits(2, v);   // 0..3 idle cycles
                repeat (int'(v)) begin
                    @(posedge clk);
                    pix_valid <= 1'b0;
                    pix_sof   <= 1'b0;
                end
            end
            rand_bits(PIX_W, v);
            @(posedge clk);
            pix_data  <= v[PIX_W-1:0];
            pix_valid <= 1'b1;
            pix_sof   <= sof && (i == 0);
        end
        @(posedge clk);
        pix_valid <= 1'b0;
        pix_sof   <= 1'b0;
    endtask

    // wait for the pipe to empty, then a few cycles for stray pulses
    task automatic drain;
        while (exp_ch0.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    task automatic end_test(input int num, input string name, input int err_before);
        if (err_cnt == err_before) begin
            $display("test %0d %s: ok", num, name);
            tests_ok++;
        end else begin
            $display("test %0d %s: %0d errors", num, name, err_cnt - err_before);
            tests_bad++;
        end
    endtask

    ////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= LIMIT) begin
            $display("timeout: no finish after %0d cycles", cyc);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] v, rd;
        logic [1:0] resp;
        logic [ADDR_W-1:0] a;
        int t_err;
        arst_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = (DATA_W/8)'(1);   // byte lane 0 only
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        pix_data = '0;
        pix_valid = 1'b0;
        pix_sof = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        // 1: register map, write then read back
        t_err = err_cnt;
        for (int i = 0; i <= TAPS; i++) begin
            a = (i == 0) ? REG_CTRL : REG_W0 + ADDR_W'(4 * (i - 1));
            rand_bits(8, v);
            axi_write(a, v[7:0], resp);
            if (resp != RESP_OKAY) report_mismatch("bresp", RESP_OKAY, resp);
            if (i == 0) m_mode = v[0];
            else m_wt[i-1] = v[7:0];
            axi_read(a, rd, resp);
            if (resp != RESP_OKAY) report_mismatch("rresp", RESP_OKAY, resp);
            if (i == 0 && rd != DATA_W'(v[0])) report_mismatch("rdata", int'(v[0]), int'(rd));
            if (i != 0 && rd != DATA_W'(v[7:0])) report_mismatch("rdata", int'(v[7:0]), int'(rd));
        end
        axi_write(ADDR_W'('h28), 8'hA5, resp);   // past the last tap
        if (resp != RESP_SLVERR) report_mismatch("bresp", RESP_SLVERR, resp);
        axi_read(ADDR_W'('h28), rd, resp);
        if (resp != RESP_SLVERR) report_mismatch("rresp", RESP_SLVERR, resp);
        for (int i = 0; i < TAPS; i++) begin
            axi_read(REG_W0 + ADDR_W'(4 * i), rd, resp);
            if (rd != DATA_W'(m_wt[i])) report_mismatch("rdata", int'(m_wt[i]), int'(rd));
        end
        end_test(1, "register access", t_err);

        // 2: mode 0, single channel
        t_err = err_cnt;
        load_kernel(1'b0);
        res_cnt = 0;
        send_frame(IMG_W * IMG_H, 1'b1, 1'b0);
        drain();
        if (res_cnt != WINS) report_mismatch("res_valid count", WINS, res_cnt);
        end_test(2, "mode 0 convolution", t_err);

        // 3: mode 1, both nibble kernels
        t_err = err_cnt;
        load_kernel(1'b1);
        res_cnt = 0;
        send_frame(IMG_W * IMG_H, 1'b1, 1'b0);
        drain();
        if (res_cnt != WINS) report_mismatch("res_valid count", WINS, res_cnt);
        end_test(3, "mode 1 dual channel", t_err);

        // 4: back-to-back pixels, exact 3-cycle latency
        t_err = err_cnt;
        load_kernel(1'b0);
        res_cnt = 0;
        lat_chk = 1'b1;
        send_frame(IMG_W * IMG_H, 1'b1, 1'b0);
        drain();
        lat_chk = 1'b0;
        if (res_cnt != WINS) report_mismatch("res_valid count", WINS, res_cnt);
        end_test(4, "latency and throughput", t_err);

        // 5: gaps, then sof partway into row 2
        t_err = err_cnt;
        res_cnt = 0;
        send_frame(2 * IMG_W + 4, 1'b1, 1'b1);   // two windows before restart
        send_frame(IMG_W * IMG_H, 1'b1, 1'b1);
        drain();
        if (res_cnt != WINS + 2) report_mismatch("res_valid count", WINS + 2, res_cnt);
        end_test(5, "gapped stream and restart", t_err);

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- conv_front.f
verilog/conv_front_pkg.sv
verilog/conv_cfg_regs.sv
verilog/window_gen.sv
verilog/pe_row.sv
verilog/sum_stage.sv
verilog/conv_datapath_front.sv
tests/conv_datapath_front_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the conv front end testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module conv_datapath_front_tb \
    -f conv_front.f -o conv_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/conv_sim | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0
